//--- design/fv_store_pkg.sv
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fv_num must be 1 to max_fv; a bank address is {slot, line}
// even node ids map to bank 0, odd ones to bank 1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fv_store_pkg;

    // one line holds two 16-bit feature values
    localparam int fv_w = 32;
    localparam int lines_per_node = 8;
    localparam int max_fv = 16;
    localparam int fv_num_w = $clog2(max_fv + 1);
    localparam int node_id_w = 6;
    localparam int iter_w = 3;
    localparam int nodes_per_iter = 4;
    localparam int pe_tag_w = 2;
    localparam int addr_w = 8;

    // address split
    localparam int line_w = $clog2(lines_per_node);
    localparam int slot_w = addr_w - line_w;
    localparam int node_cnt_w = $clog2(nodes_per_iter);
    localparam logic [node_cnt_w-1:0] last_node = node_cnt_w'(nodes_per_iter - 1);

    // request from the compute side or an edge PE
    typedef struct packed {
        logic                 valid;
        logic                 rd_wr;
        logic                 wr_eos;
        logic [node_id_w-1:0] node_id;
        logic [pe_tag_w-1:0]  pe_tag;
        logic [fv_w-1:0]      data;
    } fv_req_t;

    // SRAM port, enables active low
    typedef struct packed {
        logic              cen_n;
        logic              wen_n;
        logic [addr_w-1:0] addr;
        logic [fv_w-1:0]   wdata;
    } fv_sram_req_t;

    typedef struct packed {
        logic            valid;
        logic            sos;
        logic            eos;
        logic [fv_w-1:0] data;
    } fv_strm_t;

    typedef struct packed {
        logic                valid;
        logic                sos;
        logic                eos;
        logic [pe_tag_w-1:0] pe_tag;
        logic [fv_w-1:0]     data;
    } fv_rd_t;

    // bank 1 in the upper half
    typedef struct packed {
        logic              valid;
        logic              sos;
        logic              eos;
        logic [2*fv_w-1:0] data;
    } fv_wide_strm_t;

endpackage

`default_nettype wire

//--- design/fv_sram.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// contents are undefined until written
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fv_sram #(
    parameter int depth = 256
) (
    input  logic                          clk,
    input  fv_store_pkg::fv_sram_req_t    sram,
    output logic [fv_store_pkg::fv_w-1:0] rdata
);

    localparam int aw = $clog2(depth);

    logic [fv_store_pkg::fv_w-1:0] mem [depth];

    // write when both enables are low, else read with one cycle latency
    always_ff @(posedge clk) begin
        if (!sram.cen_n) begin
            if (!sram.wen_n) begin
                mem[sram.addr[aw-1:0]] <= sram.wdata;
            end else begin
                rdata <= mem[sram.addr[aw-1:0]];
            end
        end
    end

    // rdata holds its value between reads

endmodule

`default_nettype wire

//--- design/fv_bank_cntl.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// no handshake; stream triggers and requests only count while available
// beats appear 2 cycles after their SRAM read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fv_bank_cntl #(
    parameter bit BANK_ID = 1'b0
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [fv_store_pkg::iter_w-1:0]   replay_iter,
    input  logic [fv_store_pkg::iter_w-1:0]   update_iter,
    input  logic [fv_store_pkg::fv_num_w-1:0] fv_num,
    input  logic                              stream_begin,
    input  fv_store_pkg::fv_req_t             req,
    input  logic [fv_store_pkg::fv_w-1:0]     sram_rdata,
    output fv_store_pkg::fv_sram_req_t        sram,
    output fv_store_pkg::fv_strm_t            strm,
    output fv_store_pkg::fv_rd_t              rd,
    output logic                              available
);

    typedef enum logic [1:0] {
        st_idle,
        st_strm,
        st_wb,
        st_rd
    } state_t;

    // beat whose SRAM read is in progress
    typedef struct packed {
        logic                              valid;
        logic                              sos;
        logic                              eos;
        logic                              is_strm;
        logic [fv_store_pkg::pe_tag_w-1:0] pe_tag;
    } pend_t;

    state_t state;
    state_t state_d;
    pend_t  pend;
    pend_t  pend_d;

    logic [fv_store_pkg::line_w-1:0]     line_cnt;
    logic [fv_store_pkg::line_w-1:0]     line_d;
    logic [fv_store_pkg::node_cnt_w-1:0] node_cnt;
    logic [fv_store_pkg::node_cnt_w-1:0] node_d;
    logic [fv_store_pkg::iter_w-1:0]     last_iter;
    logic [fv_store_pkg::iter_w-1:0]     last_iter_d;
    logic [fv_store_pkg::line_w-1:0]     last_line_q;
    logic [fv_store_pkg::slot_w-1:0]     slot_q;
    logic [fv_store_pkg::pe_tag_w-1:0]   tag_q;
    logic                                out_q;

    logic [fv_store_pkg::fv_num_w-1:0]   fv_num_m1;
    logic [fv_store_pkg::line_w-1:0]     cur_line;
    logic [fv_store_pkg::line_w-1:0]     cur_last;
    logic [fv_store_pkg::node_cnt_w-1:0] cur_node;
    logic [fv_store_pkg::slot_w-1:0]     cur_slot;
    logic [fv_store_pkg::pe_tag_w-1:0]   cur_tag;
    logic [fv_store_pkg::iter_w-1:0]     cur_iter;

    logic idle;
    logic ready;
    logic strm_go;
    logic req_go;
    logic end_of_node;
    logic end_of_iter;
    logic do_strm;
    logic do_rd;
    logic do_wr;

    assign idle = (state == st_idle);

    // idle and drained, including the beat held in the merge register
    assign ready = idle && !pend.valid && !strm.valid && !rd.valid && !out_q;
    assign available = ready;

    // stream phase on even update iterations, requests on odd ones
    assign strm_go = ready && !update_iter[0] &&
                     (stream_begin || (replay_iter != last_iter));
    assign req_go = ready && update_iter[0] && req.valid &&
                    (req.node_id[0] == BANK_ID);

    // context comes from the inputs in the accepting cycle, then from the latches
    assign fv_num_m1 = fv_num - 1'b1;
    assign cur_line = idle ? '0 : line_cnt;
    assign cur_node = idle ? '0 : node_cnt;
    assign cur_last = idle ? fv_num_m1[fv_store_pkg::line_w:1] : last_line_q;
    assign cur_slot = idle ? req.node_id[fv_store_pkg::node_id_w-1:1] : slot_q;
    assign cur_tag = idle ? req.pe_tag : tag_q;
    assign cur_iter = idle ? replay_iter : last_iter;

    assign end_of_node = (cur_line == cur_last);
    assign end_of_iter = end_of_node && (cur_node == fv_store_pkg::last_node);

    assign do_strm = strm_go || (state == st_strm);
    assign do_rd = (req_go && !req.rd_wr) || (state == st_rd);
    assign do_wr = (req_go && req.rd_wr) || ((state == st_wb) && req.valid);

    always_comb begin
        state_d = state;
        line_d = line_cnt;
        node_d = node_cnt;
        last_iter_d = last_iter;
        pend_d = '0;
        sram.cen_n = 1'b1;
        sram.wen_n = 1'b1;
        sram.addr = '0;
        sram.wdata = '0;

        if (do_strm) begin
            // stream slot is iter * 4 + node count
            sram.cen_n = 1'b0;
            sram.addr = {cur_iter, cur_node, cur_line};
            pend_d.valid = 1'b1;
            pend_d.sos = idle;
            pend_d.eos = end_of_iter;
            pend_d.is_strm = 1'b1;
            last_iter_d = cur_iter;
            state_d = end_of_iter ? st_idle : st_strm;
            if (end_of_iter) begin
                line_d = '0;
                node_d = '0;
            end else if (end_of_node) begin
                line_d = '0;
                node_d = cur_node + 1'b1;
            end else begin
                line_d = cur_line + 1'b1;
                node_d = cur_node;
            end
        end else if (do_rd) begin
            sram.cen_n = 1'b0;
            sram.addr = {cur_slot, cur_line};
            pend_d.valid = 1'b1;
            pend_d.sos = idle;
            pend_d.eos = end_of_node;
            pend_d.pe_tag = cur_tag;
            state_d = end_of_node ? st_idle : st_rd;
            line_d = end_of_node ? '0 : cur_line + 1'b1;
        end else if (do_wr) begin
            // one line per cycle, wr_eos closes the burst
            sram.cen_n = 1'b0;
            sram.wen_n = 1'b0;
            sram.addr = {cur_slot, cur_line};
            sram.wdata = req.data;
            state_d = req.wr_eos ? st_idle : st_wb;
            line_d = req.wr_eos ? '0 : cur_line + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= st_idle;
            line_cnt <= '0;
            node_cnt <= '0;
            last_iter <= '0;
            pend <= '0;
            strm <= '0;
            rd <= '0;
            out_q <= 1'b0;
        end else begin
            state <= state_d;
            line_cnt <= line_d;
            node_cnt <= node_d;
            last_iter <= last_iter_d;
            pend <= pend_d;

            // data phase, rdata belongs to the pending beat
            strm.valid <= pend.valid && pend.is_strm;
            strm.sos <= pend.sos && pend.is_strm;
            strm.eos <= pend.eos && pend.is_strm;
            strm.data <= sram_rdata;
            rd.valid <= pend.valid && !pend.is_strm;
            rd.sos <= pend.sos && !pend.is_strm;
            rd.eos <= pend.eos && !pend.is_strm;
            rd.pe_tag <= pend.pe_tag;
            rd.data <= sram_rdata;

            // mirrors the merge output stage
            out_q <= strm.valid || rd.valid;
        end
    end

    // latches follow the inputs while idle and hold once busy
    always_ff @(posedge clk) begin
        last_line_q <= cur_last;
        slot_q <= cur_slot;
        tag_q <= cur_tag;
    end

endmodule

`default_nettype wire

//--- design/fv_merge.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// both banks must stream in lockstep; bank 0 frames the wide beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fv_merge (
    input  logic                        clk,
    input  logic                        reset,
    input  fv_store_pkg::fv_strm_t      strm0,
    input  fv_store_pkg::fv_strm_t      strm1,
    input  fv_store_pkg::fv_rd_t        rd0,
    input  fv_store_pkg::fv_rd_t        rd1,
    input  logic                        avail0,
    input  logic                        avail1,
    output fv_store_pkg::fv_wide_strm_t strm_out,
    output fv_store_pkg::fv_rd_t        rd_out,
    output logic                        available
);

    fv_store_pkg::fv_wide_strm_t strm_d;
    fv_store_pkg::fv_rd_t        rd_d;

    // pair the lanes, bank 1 on top
    always_comb begin
        strm_d.valid = strm0.valid;
        strm_d.sos = strm0.sos;
        strm_d.eos = strm0.eos;
        strm_d.data = {strm1.data, strm0.data};
    end

    // only one bank answers an edge read at a time
    always_comb begin
        if (rd0.valid) begin
            rd_d = rd0;
        end else if (rd1.valid) begin
            rd_d = rd1;
        end else begin
            rd_d = '0;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            strm_out <= '0;
            rd_out <= '0;
        end else begin
            strm_out <= strm_d;
            rd_out <= rd_d;
        end
    end

    // store is free only when both banks are
    assign available = avail0 && avail1;

endmodule

`default_nettype wire

//--- design/fv_store_top.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// requesters must watch available; there is no back-pressure
// reads and streams leave the top 3 cycles after acceptance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fv_store_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [fv_store_pkg::iter_w-1:0]   replay_iter,
    input  logic [fv_store_pkg::iter_w-1:0]   update_iter,
    input  logic [fv_store_pkg::fv_num_w-1:0] fv_num,
    input  logic                              stream_begin,
    input  fv_store_pkg::fv_req_t             req,
    output fv_store_pkg::fv_wide_strm_t       strm_out,
    output fv_store_pkg::fv_rd_t              rd_out,
    output logic                              available
);

    localparam int sram_depth = 1 << fv_store_pkg::addr_w;

    fv_store_pkg::fv_sram_req_t    sram0;
    fv_store_pkg::fv_sram_req_t    sram1;
    logic [fv_store_pkg::fv_w-1:0] sram0_rdata;
    logic [fv_store_pkg::fv_w-1:0] sram1_rdata;
    fv_store_pkg::fv_strm_t        strm0;
    fv_store_pkg::fv_strm_t        strm1;
    fv_store_pkg::fv_rd_t          rd0;
    fv_store_pkg::fv_rd_t          rd1;
    logic                          avail0;
    logic                          avail1;

    // even node ids
    fv_sram #(
        .depth(sram_depth)
    ) u_sram0 (
        .clk  (clk),
        .sram (sram0),
        .rdata(sram0_rdata)
    );

    // odd node ids
    fv_sram #(
        .depth(sram_depth)
    ) u_sram1 (
        .clk  (clk),
        .sram (sram1),
        .rdata(sram1_rdata)
    );

    fv_bank_cntl #(
        .BANK_ID(1'b0)
    ) u_cntl0 (
        .clk         (clk),
        .reset       (reset),
        .replay_iter (replay_iter),
        .update_iter (update_iter),
        .fv_num      (fv_num),
        .stream_begin(stream_begin),
        .req         (req),
        .sram_rdata  (sram0_rdata),
        .sram        (sram0),
        .strm        (strm0),
        .rd          (rd0),
        .available   (avail0)
    );

    fv_bank_cntl #(
        .BANK_ID(1'b1)
    ) u_cntl1 (
        .clk         (clk),
        .reset       (reset),
        .replay_iter (replay_iter),
        .update_iter (update_iter),
        .fv_num      (fv_num),
        .stream_begin(stream_begin),
        .req         (req),
        .sram_rdata  (sram1_rdata),
        .sram        (sram1),
        .strm        (strm1),
        .rd          (rd1),
        .available   (avail1)
    );

    fv_merge u_merge (
        .clk      (clk),
        .reset    (reset),
        .strm0    (strm0),
        .strm1    (strm1),
        .rd0      (rd0),
        .rd1      (rd1),
        .avail0   (avail0),
        .avail1   (avail1),
        .strm_out (strm_out),
        .rd_out   (rd_out),
        .available(available)
    );

endmodule

`default_nettype wire

//--- dv/fv_store_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound into fv_store_top; checks output framing only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fv_store_asserts (
    input logic                        clk,
    input logic                        reset,
    input fv_store_pkg::fv_wide_strm_t strm_out,
    input fv_store_pkg::fv_rd_t        rd_out,
    input logic                        available
);

    // a read frame runs to eos without a gap or a second sos
    rd_frame_contiguous: assert property (@(posedge clk) disable iff (!reset)
        (rd_out.valid && !rd_out.eos) |=> (rd_out.valid && !rd_out.sos))
        else $error("rd_out frame broken before eos");

    // no gap between sos and eos
    strm_no_gap: assert property (@(posedge clk) disable iff (!reset)
        (strm_out.valid && !strm_out.eos) |=> strm_out.valid)
        else $error("strm_out valid dropped inside a stream frame");

    // store is busy while any beat leaves
    busy_while_beat: assert property (@(posedge clk) disable iff (!reset)
        (strm_out.valid || rd_out.valid) |-> !available)
        else $error("available high while an output beat is valid");

endmodule

`default_nettype wire

//--- dv/fv_store_tb.sv
`timescale 1ns/1ps
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// requests go out only while available; beats are sampled on the falling edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fv_store_tb;

    localparam int nodes = 1 << fv_store_pkg::node_id_w;
    localparam int lines = fv_store_pkg::lines_per_node;
    localparam int per_iter = fv_store_pkg::nodes_per_iter;

    logic                              clk = 1'b0;
    logic                              reset;
    logic [fv_store_pkg::iter_w-1:0]   replay_iter;
    logic [fv_store_pkg::iter_w-1:0]   update_iter;
    logic [fv_store_pkg::fv_num_w-1:0] fv_num;
    logic                              stream_begin;
    fv_store_pkg::fv_req_t             req;
    fv_store_pkg::fv_wide_strm_t       strm_out;
    fv_store_pkg::fv_rd_t              rd_out;
    logic                              available;

    logic [fv_store_pkg::fv_w-1:0] model [nodes][lines];
    fv_store_pkg::fv_rd_t          rd_q [$];
    fv_store_pkg::fv_wide_strm_t   strm_q [$];
    int rd_cyc [$];
    int strm_cyc [$];
    int cyc = 0;
    int errors = 0;
    int tests = 0;
    int failed = 0;
    int last_strm = 0;
    int picked [6];

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // every valid beat with the cycle it appeared in
    always @(negedge clk) begin
        if (rd_out.valid) begin
            rd_q.push_back(rd_out);
            rd_cyc.push_back(cyc);
        end
        if (strm_out.valid) begin
            strm_q.push_back(strm_out);
            strm_cyc.push_back(cyc);
        end
    end

    fv_store_top u_fv_store_top (
        .clk         (clk),
        .reset       (reset),
        .replay_iter (replay_iter),
        .update_iter (update_iter),
        .fv_num      (fv_num),
        .stream_begin(stream_begin),
        .req         (req),
        .strm_out    (strm_out),
        .rd_out      (rd_out),
        .available   (available)
    );

    bind fv_store_top fv_store_asserts u_asserts (
        .clk      (clk),
        .reset    (reset),
        .strm_out (strm_out),
        .rd_out   (rd_out),
        .available(available)
    );

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: %s expected %h actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic close_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    task automatic wait_idle(input string name);
        int n;
        n = 0;
        while (!available && n < 200) begin
            tick();
            n++;
        end
        if (!available) begin
            $display("%s: store never became available", name);
            errors++;
        end
    endtask

    function automatic int beat_count(input bit from_strm);
        return from_strm ? strm_q.size() : rd_q.size();
    endfunction

    task automatic wait_beats(input int want, input bit from_strm, input string name);
        int n;
        n = 0;
        while (beat_count(from_strm) < want && n < 200) begin
            tick();
            n++;
        end
        if (beat_count(from_strm) < want) begin
            $display("%s: timed out waiting for output beats", name);
            errors++;
        end
        // room for stray beats
        repeat (4) tick();
    endtask

    task automatic write_node(input int node);
        wait_idle("write");
        for (int l = 0; l < lines; l++) begin
            model[node][l] = $urandom;
            req.valid = 1'b1;
            req.rd_wr = 1'b1;
            req.wr_eos = (l == lines - 1);
            req.node_id = fv_store_pkg::node_id_w'(node);
            req.data = model[node][l];
            tick();
        end
        req = '0;
    endtask

    task automatic read_node(input int node, input int fvn, input bit intrude,
                             input string name);
        int n;
        int c0;
        logic [fv_store_pkg::pe_tag_w-1:0] tag;
        n = (fvn + 1) / 2;
        tag = fv_store_pkg::pe_tag_w'($urandom);
        wait_idle(name);
        fv_num = fv_store_pkg::fv_num_w'(fvn);
        rd_q.delete();
        rd_cyc.delete();
        c0 = cyc;
        req.valid = 1'b1;
        req.rd_wr = 1'b0;
        req.node_id = fv_store_pkg::node_id_w'(node);
        req.pe_tag = tag;
        tick();
        req.valid = 1'b0;
        if (intrude) begin
            // a same-bank request while busy must be dropped
            check_value(name, "available during read", 64'(0), 64'(available));
            req.valid = 1'b1;
            req.node_id = fv_store_pkg::node_id_w'(node ^ 2);
            tick();
            req.valid = 1'b0;
        end
        wait_beats(n, 1'b0, name);
        check_value(name, "read beat count", 64'(n), 64'(rd_q.size()));
        for (int i = 0; i < rd_q.size() && i < n; i++) begin
            check_value(name, "read data", 64'(model[node][i]), 64'(rd_q[i].data));
            check_value(name, "read {sos,eos,tag}", 64'({i == 0, i == n - 1, tag}),
                        64'({rd_q[i].sos, rd_q[i].eos, rd_q[i].pe_tag}));
            check_value(name, "read cycle", 64'(c0 + 3 + i), 64'(rd_cyc[i]));
        end
    endtask

    task automatic stream_iter(input int iter, input bit use_begin, input bit intrude,
                               input string name);
        int fvn;
        int n;
        int c0;
        int slot;
        logic [2*fv_store_pkg::fv_w-1:0] exp;
        fvn = 1 + int'($urandom % 16);
        n = (fvn + 1) / 2;
        update_iter = 3'd1;
        for (int k = 0; k < per_iter; k++) begin
            write_node(2 * (iter * per_iter + k));
            write_node(2 * (iter * per_iter + k) + 1);
        end
        wait_idle(name);
        fv_num = fv_store_pkg::fv_num_w'(fvn);
        strm_q.delete();
        strm_cyc.delete();
        rd_q.delete();
        update_iter = 3'd2;
        if (!use_begin) begin
            // even phase alone starts nothing
            repeat (4) tick();
            check_value(name, "beats before iteration change", 64'(0), 64'(strm_q.size()));
        end
        c0 = cyc;
        if (use_begin) begin
            stream_begin = 1'b1;
        end else begin
            replay_iter = fv_store_pkg::iter_w'(iter);
        end
        tick();
        stream_begin = 1'b0;
        if (intrude) begin
            check_value(name, "available during stream", 64'(0), 64'(available));
            update_iter = 3'd1;
            req.valid = 1'b1;
            tick();
            req = '0;
        end
        wait_beats(per_iter * n, 1'b1, name);
        check_value(name, "stream beat count", 64'(per_iter * n), 64'(strm_q.size()));
        check_value(name, "read beats during stream", 64'(0), 64'(rd_q.size()));
        for (int j = 0; j < strm_q.size() && j < per_iter * n; j++) begin
            slot = iter * per_iter + j / n;
            exp = {model[2 * slot + 1][j % n], model[2 * slot][j % n]};
            check_value(name, "stream data", exp, strm_q[j].data);
            check_value(name, "stream {sos,eos}", 64'({j == 0, j == per_iter * n - 1}),
                        64'({strm_q[j].sos, strm_q[j].eos}));
            check_value(name, "stream cycle", 64'(c0 + 3 + j), 64'(strm_cyc[j]));
        end
        update_iter = 3'd1;
        last_strm = iter;
    endtask

    initial begin
        int err0;
        int fvn;
        void'($urandom(32'h24f));
        reset = 1'b0;
        replay_iter = '0;
        update_iter = 3'd1;
        fv_num = fv_store_pkg::fv_num_w'(fv_store_pkg::max_fv);
        stream_begin = 1'b0;
        req = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b1;

        err0 = errors;
        check_value("reset", "available", 64'(1), 64'(available));
        check_value("reset", "rd_out flags", 64'(0),
                    64'({rd_out.valid, rd_out.sos, rd_out.eos}));
        check_value("reset", "strm_out flags", 64'(0),
                    64'({strm_out.valid, strm_out.sos, strm_out.eos}));
        close_test("reset", err0);

        // both banks with alternating parity
        err0 = errors;
        for (int i = 0; i < 6; i++) begin
            picked[i] = 2 * int'($urandom % 32) + i % 2;
            write_node(picked[i]);
        end
        for (int i = 0; i < 6; i++) begin
            read_node(picked[i], fv_store_pkg::max_fv, 1'b0, "write_read");
        end
        close_test("write_read", err0);

        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            fvn = 2 * int'($urandom % 8) + 1;
            read_node(picked[int'($urandom % 6)], fvn, 1'b0, "odd_fv_num");
        end
        close_test("odd_fv_num", err0);

        err0 = errors;
        stream_iter(last_strm, 1'b1, 1'b0, "stream_begin");
        close_test("stream_begin", err0);

        err0 = errors;
        stream_iter((last_strm + 1 + int'($urandom % 7)) % 8, 1'b0, 1'b0, "iter_change");
        close_test("iter_change", err0);

        err0 = errors;
        read_node(picked[0], fv_store_pkg::max_fv, 1'b1, "busy");
        stream_iter(last_strm, 1'b1, 1'b1, "busy");
        close_test("busy", err0);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fv_store_top.f
design/fv_store_pkg.sv
design/fv_sram.sv
design/fv_bank_cntl.sv
design/fv_merge.sv
design/fv_store_top.sv
dv/fv_store_asserts.sv
dv/fv_store_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := fv_store_tb
FILELIST  := fv_store_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
